/* exu_params.svh */
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

// data path and pc width
`define XLEN 32

// rd index, x0..x31
`define REG_ADDRWIDTH 5

// csr address space
`define CSR_ADDRWIDTH 12

`define PC_STEP 4 // bytes per instruction, no compressed set

`endif

/* exu_pkg.sv */
`default_nettype none

package exu_pkg;

  // instruction class, picks the operand routing
  typedef enum logic [3:0] {
    EXC_NONE,
    EXC_OPREG,
    EXC_OPIMM,
    EXC_LOAD,
    EXC_STORE,
    EXC_BRANCH,
    EXC_JAL,
    EXC_JALR,
    EXC_AUIPC,
    EXC_LUI,
    EXC_CSR
  } exc_op_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_BEQ,
    BR_BNE,
    BR_BLT,
    BR_BGE,
    BR_BLTU,
    BR_BGEU
  } br_op_e;

  typedef enum logic [1:0] {
    CSR_NONE,
    CSR_RW,
    CSR_RS,
    CSR_RC
  } csr_op_e;

endpackage

`default_nettype wire

/* ex_issue_if.sv */
`default_nettype none
`include "exu_params.svh"

interface ex_issue_if;

  logic                      valid;
  exu_pkg::exc_op_e          exc_op;
  exu_pkg::alu_op_e          alu_op;
  exu_pkg::br_op_e           br_op;
  exu_pkg::csr_op_e          csr_op;
  logic [`XLEN-1:0]          pc;
  logic [`XLEN-1:0]          op_a;       // already selected by class
  logic [`XLEN-1:0]          op_b;
  logic [`XLEN-1:0]          imm;
  logic [`XLEN-1:0]          rs1_data;   // raw, for jalr target and csr source
  logic [`XLEN-1:0]          csr_data;   // old csr value
  logic [`CSR_ADDRWIDTH-1:0] csr_addr;
  logic [4:0]                csr_uimm;
  logic                      csr_uimm_sel;
  logic [`REG_ADDRWIDTH-1:0] rd;
  logic                      pdt_taken;

  modport issue (
    output valid, exc_op, alu_op, br_op, csr_op, pc, op_a, op_b, imm, rs1_data,
           csr_data, csr_addr, csr_uimm, csr_uimm_sel, rd, pdt_taken
  );

  modport exec (
    input valid, exc_op, alu_op, br_op, csr_op, pc, op_a, op_b, imm, rs1_data,
          csr_data, csr_addr, csr_uimm, csr_uimm_sel, rd, pdt_taken
  );

endinterface

`default_nettype wire

/* ex_result_if.sv */
`default_nettype none
`include "exu_params.svh"

// combinational results of the instruction sitting in the issue register
interface ex_result_if;

  logic [`XLEN-1:0] alu_out;
  logic             cmp_out;
  logic [`XLEN-1:0] redirect_pc;
  logic             mispredict;
  logic             branch_taken;
  logic [`XLEN-1:0] csr_wdata;

  modport alu (output alu_out, cmp_out);

  modport branch (input cmp_out, output redirect_pc, mispredict, branch_taken);

  modport csr (output csr_wdata);

  modport sink (input alu_out, cmp_out, redirect_pc, mispredict, branch_taken, csr_wdata);

endinterface

`default_nettype wire

/* ex_issue.sv */
`default_nettype none
`include "exu_params.svh"

module ex_issue (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic                      in_valid_i,
  input  exu_pkg::exc_op_e          exc_op_i,
  input  exu_pkg::alu_op_e          alu_op_i,
  input  exu_pkg::br_op_e           br_op_i,
  input  exu_pkg::csr_op_e          csr_op_i,
  input  logic [`XLEN-1:0]          pc_i,
  input  logic [`XLEN-1:0]          rs1_data_i,
  input  logic [`XLEN-1:0]          rs2_data_i,
  input  logic [`XLEN-1:0]          imm_i,
  input  logic [`XLEN-1:0]          csr_data_i,
  input  logic [`CSR_ADDRWIDTH-1:0] csr_addr_i,
  input  logic [4:0]                csr_uimm_i,
  input  logic                      csr_uimm_sel_i,
  input  logic [`REG_ADDRWIDTH-1:0] rd_i,
  input  logic                      pdt_taken_i,
  input  logic                      mispredict_i, // from the instruction ahead
  ex_issue_if.issue                 iss_o
);

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] imm_upper;

  assign imm_upper = {imm_i[`XLEN-1:12], 12'b0}; // lui / auipc

  always_comb begin
    op_a = '0;
    op_b = '0;
    case (exc_op_i)
      exu_pkg::EXC_OPREG, exu_pkg::EXC_BRANCH: begin
        op_a = rs1_data_i;
        op_b = rs2_data_i;
      end
      exu_pkg::EXC_OPIMM, exu_pkg::EXC_LOAD, exu_pkg::EXC_STORE: begin
        op_a = rs1_data_i;
        op_b = imm_i;
      end
      exu_pkg::EXC_JAL, exu_pkg::EXC_JALR: begin
        op_a = pc_i; // link address
        op_b = `XLEN'(`PC_STEP);
      end
      exu_pkg::EXC_AUIPC: begin
        op_a = pc_i;
        op_b = imm_upper;
      end
      exu_pkg::EXC_LUI:  op_b = imm_upper;
      exu_pkg::EXC_CSR:  op_b = csr_data_i; // old value goes to rd
      default: ;
    endcase
  end

  // squash whatever arrives behind a mispredict
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      iss_o.valid <= 1'b0;
    end else begin
      iss_o.valid <= in_valid_i & ~mispredict_i;
    end
  end

  always_ff @(posedge clk) begin
    iss_o.exc_op       <= exc_op_i;
    iss_o.alu_op       <= alu_op_i;
    iss_o.br_op        <= br_op_i;
    iss_o.csr_op       <= csr_op_i;
    iss_o.pc           <= pc_i;
    iss_o.op_a         <= op_a;
    iss_o.op_b         <= op_b;
    iss_o.imm          <= imm_i;
    iss_o.rs1_data     <= rs1_data_i;
    iss_o.csr_data     <= csr_data_i;
    iss_o.csr_addr     <= csr_addr_i;
    iss_o.csr_uimm     <= csr_uimm_i;
    iss_o.csr_uimm_sel <= csr_uimm_sel_i;
    iss_o.rd           <= rd_i;
    iss_o.pdt_taken    <= pdt_taken_i;
  end

  a_alu_op_known: assert property (
    @(posedge clk) disable iff (!rst_n_i) in_valid_i |-> !$isunknown(alu_op_i)
  );

endmodule

`default_nettype wire

/* ex_alu.sv */
`default_nettype none
`include "exu_params.svh"

module ex_alu (
  input  logic      clk,
  input  logic      rst_n_i,
  ex_issue_if.exec  iss_i,
  ex_result_if.alu  res_o
);

  logic [`XLEN-1:0] a;
  logic [`XLEN-1:0] b;
  logic [4:0]       shamt;
  logic             lt_s;
  logic             lt_u;
  logic             eq;

  assign a     = iss_i.op_a;
  assign b     = iss_i.op_b;
  assign shamt = b[4:0];

  // shared by slt/sltu and the branch compare
  assign lt_s = $signed(a) < $signed(b);
  assign lt_u = a < b;
  assign eq   = a == b;

  always_comb begin
    case (iss_i.alu_op)
      exu_pkg::ALU_ADD:  res_o.alu_out = a + b;
      exu_pkg::ALU_SUB:  res_o.alu_out = a - b;
      exu_pkg::ALU_SLL:  res_o.alu_out = a << shamt;
      exu_pkg::ALU_SLT:  res_o.alu_out = `XLEN'(lt_s);
      exu_pkg::ALU_SLTU: res_o.alu_out = `XLEN'(lt_u);
      exu_pkg::ALU_XOR:  res_o.alu_out = a ^ b;
      exu_pkg::ALU_SRL:  res_o.alu_out = a >> shamt;
      exu_pkg::ALU_SRA:  res_o.alu_out = $signed(a) >>> shamt;
      exu_pkg::ALU_OR:   res_o.alu_out = a | b;
      exu_pkg::ALU_AND:  res_o.alu_out = a & b;
      default:           res_o.alu_out = a + b;
    endcase
  end

  always_comb begin
    case (iss_i.br_op)
      exu_pkg::BR_BEQ:  res_o.cmp_out = eq;
      exu_pkg::BR_BNE:  res_o.cmp_out = ~eq;
      exu_pkg::BR_BLT:  res_o.cmp_out = lt_s;
      exu_pkg::BR_BGE:  res_o.cmp_out = ~lt_s;
      exu_pkg::BR_BLTU: res_o.cmp_out = lt_u;
      exu_pkg::BR_BGEU: res_o.cmp_out = ~lt_u;
      default:          res_o.cmp_out = 1'b0;
    endcase
  end

  // upstream must never issue a bubble marked valid
  a_no_none_class: assert property (
    @(posedge clk) disable iff (!rst_n_i) iss_i.valid |-> iss_i.exc_op != exu_pkg::EXC_NONE
  );

endmodule

`default_nettype wire

/* ex_branch.sv */
`default_nettype none
`include "exu_params.svh"

module ex_branch (
  input  logic        clk,
  input  logic        rst_n_i,
  ex_issue_if.exec    iss_i,
  ex_result_if.branch res_io,
  output logic        mispredict_o  // squash to ex_issue
);

  logic             is_br;
  logic             is_jalr;
  logic             is_jump;
  logic             taken;
  logic [`XLEN-1:0] jalr_sum;

  assign is_br   = iss_i.exc_op == exu_pkg::EXC_BRANCH;
  assign is_jalr = iss_i.exc_op == exu_pkg::EXC_JALR;
  assign is_jump = is_br | is_jalr | (iss_i.exc_op == exu_pkg::EXC_JAL);

  assign taken    = is_br ? res_io.cmp_out : is_jump; // jumps always taken
  assign jalr_sum = iss_i.rs1_data + iss_i.imm;

  always_comb begin
    if (iss_i.pdt_taken && !taken) begin
      res_io.redirect_pc = iss_i.pc + `XLEN'(`PC_STEP); // fall through
    end else if (is_jalr) begin
      res_io.redirect_pc = {jalr_sum[`XLEN-1:1], 1'b0};
    end else begin
      res_io.redirect_pc = iss_i.pc + iss_i.imm;
    end
  end

  assign mispredict_o        = iss_i.valid & is_jump & (taken != iss_i.pdt_taken);
  assign res_io.mispredict   = mispredict_o;
  assign res_io.branch_taken = taken;

  // the slot behind a mispredict comes up empty
  a_mispredict_squashes: assert property (
    @(posedge clk) disable iff (!rst_n_i) mispredict_o |=> !iss_i.valid
  );

endmodule

`default_nettype wire

/* ex_csr.sv */
`default_nettype none
`include "exu_params.svh"

module ex_csr (
  ex_issue_if.exec iss_i,
  ex_result_if.csr res_o
);

  logic [`XLEN-1:0] src;

  // csrrwi / csrrsi / csrrci take the zero-extended uimm
  assign src = iss_i.csr_uimm_sel ? `XLEN'(iss_i.csr_uimm) : iss_i.rs1_data;

  always_comb begin
    case (iss_i.csr_op)
      exu_pkg::CSR_RW: res_o.csr_wdata = src;
      exu_pkg::CSR_RS: res_o.csr_wdata = iss_i.csr_data | src;  // set bits
      exu_pkg::CSR_RC: res_o.csr_wdata = iss_i.csr_data & ~src; // clear bits
      default:         res_o.csr_wdata = iss_i.csr_data;
    endcase
  end

endmodule

`default_nettype wire

/* ex_retire.sv */
`default_nettype none
`include "exu_params.svh"

module ex_retire (
  input  logic                      clk,
  input  logic                      rst_n_i,
  ex_issue_if.exec                  iss_i,
  ex_result_if.sink                 res_i,
  output logic                      out_valid_o,
  output logic [`REG_ADDRWIDTH-1:0] rd_o,
  output logic [`XLEN-1:0]          result_o,
  output logic                      csr_we_o,
  output logic [`CSR_ADDRWIDTH-1:0] csr_addr_o,
  output logic [`XLEN-1:0]          csr_wdata_o,
  output logic                      branch_valid_o,
  output logic                      branch_taken_o,
  output logic                      redirect_valid_o,
  output logic [`XLEN-1:0]          redirect_pc_o
);

  logic is_csr_wr;
  logic is_jump;

  assign is_csr_wr = (iss_i.exc_op == exu_pkg::EXC_CSR) && (iss_i.csr_op != exu_pkg::CSR_NONE);
  assign is_jump   = iss_i.exc_op inside {exu_pkg::EXC_BRANCH, exu_pkg::EXC_JAL,
                                          exu_pkg::EXC_JALR};

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      out_valid_o      <= 1'b0;
      csr_we_o         <= 1'b0;
      branch_valid_o   <= 1'b0;
      redirect_valid_o <= 1'b0;
    end else begin
      out_valid_o      <= iss_i.valid;
      csr_we_o         <= iss_i.valid & is_csr_wr;
      branch_valid_o   <= iss_i.valid & is_jump;
      redirect_valid_o <= res_i.mispredict; // valid already folded in
    end
  end

  // for csr the alu hands the old value through to rd
  always_ff @(posedge clk) begin
    rd_o           <= iss_i.rd;
    result_o       <= res_i.alu_out;
    csr_addr_o     <= iss_i.csr_addr;
    csr_wdata_o    <= res_i.csr_wdata;
    branch_taken_o <= res_i.branch_taken;
    redirect_pc_o  <= res_i.redirect_pc;
  end

  a_redirect_is_branch: assert property (
    @(posedge clk) disable iff (!rst_n_i) redirect_valid_o |-> branch_valid_o
  );

endmodule

`default_nettype wire

/* exu_top.sv */
`default_nettype none
`include "exu_params.svh"

module exu_top (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic                      in_valid_i,
  input  exu_pkg::exc_op_e          exc_op_i,
  input  exu_pkg::alu_op_e          alu_op_i,
  input  exu_pkg::br_op_e           br_op_i,
  input  exu_pkg::csr_op_e          csr_op_i,
  input  logic [`XLEN-1:0]          pc_i,
  input  logic [`XLEN-1:0]          rs1_data_i,
  input  logic [`XLEN-1:0]          rs2_data_i,
  input  logic [`XLEN-1:0]          imm_i,
  input  logic [`XLEN-1:0]          csr_data_i,
  input  logic [`CSR_ADDRWIDTH-1:0] csr_addr_i,
  input  logic [4:0]                csr_uimm_i,
  input  logic                      csr_uimm_sel_i,
  input  logic [`REG_ADDRWIDTH-1:0] rd_i,
  input  logic                      pdt_taken_i,
  output logic                      out_valid_o,
  output logic [`REG_ADDRWIDTH-1:0] rd_o,
  output logic [`XLEN-1:0]          result_o,
  output logic                      csr_we_o,
  output logic [`CSR_ADDRWIDTH-1:0] csr_addr_o,
  output logic [`XLEN-1:0]          csr_wdata_o,
  output logic                      branch_valid_o,
  output logic                      branch_taken_o,
  output logic                      redirect_valid_o,
  output logic [`XLEN-1:0]          redirect_pc_o
);

  ex_issue_if  iss_if ();
  ex_result_if res_if ();

  logic mispredict; // squash path, branch back to issue

  ex_issue u_issue (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .in_valid_i     (in_valid_i),
    .exc_op_i       (exc_op_i),
    .alu_op_i       (alu_op_i),
    .br_op_i        (br_op_i),
    .csr_op_i       (csr_op_i),
    .pc_i           (pc_i),
    .rs1_data_i     (rs1_data_i),
    .rs2_data_i     (rs2_data_i),
    .imm_i          (imm_i),
    .csr_data_i     (csr_data_i),
    .csr_addr_i     (csr_addr_i),
    .csr_uimm_i     (csr_uimm_i),
    .csr_uimm_sel_i (csr_uimm_sel_i),
    .rd_i           (rd_i),
    .pdt_taken_i    (pdt_taken_i),
    .mispredict_i   (mispredict),
    .iss_o          (iss_if.issue)
  );

  ex_alu u_alu (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .iss_i   (iss_if.exec),
    .res_o   (res_if.alu)
  );

  ex_branch u_branch (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .iss_i        (iss_if.exec),
    .res_io       (res_if.branch),
    .mispredict_o (mispredict)
  );

  ex_csr u_csr (
    .iss_i (iss_if.exec),
    .res_o (res_if.csr)
  );

  ex_retire u_retire (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .iss_i            (iss_if.exec),
    .res_i            (res_if.sink),
    .out_valid_o      (out_valid_o),
    .rd_o             (rd_o),
    .result_o         (result_o),
    .csr_we_o         (csr_we_o),
    .csr_addr_o       (csr_addr_o),
    .csr_wdata_o      (csr_wdata_o),
    .branch_valid_o   (branch_valid_o),
    .branch_taken_o   (branch_taken_o),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o)
  );

endmodule

`default_nettype wire

/* tb_exu.sv */
`default_nettype none
`include "exu_params.svh"

module tb_exu;

  // one table row, instruction fields then expected outputs
  typedef struct packed {
    logic                  vld;
    exu_pkg::exc_op_e      exc;
    exu_pkg::alu_op_e      alu;
    exu_pkg::br_op_e       br;
    exu_pkg::csr_op_e      csr;
    logic [`XLEN-1:0]      pc;
    logic [`XLEN-1:0]      rs1;
    logic [`XLEN-1:0]      rs2;
    logic [`XLEN-1:0]      imm;
    logic [`XLEN-1:0]      csr_data;
    logic [4:0]            uimm;
    logic                  usel;
    logic                  pdt;
    logic [`XLEN-1:0]      exp_res;
    logic                  exp_taken;
    logic                  exp_redir;
    logic [`XLEN-1:0]      exp_rpc;
    logic [`XLEN-1:0]      exp_wdata;
  } row_t;

  logic                      clk;
  logic                      rst_n_i;
  logic                      in_valid_i;
  exu_pkg::exc_op_e          exc_op_i;
  exu_pkg::alu_op_e          alu_op_i;
  exu_pkg::br_op_e           br_op_i;
  exu_pkg::csr_op_e          csr_op_i;
  logic [`XLEN-1:0]          pc_i;
  logic [`XLEN-1:0]          rs1_data_i;
  logic [`XLEN-1:0]          rs2_data_i;
  logic [`XLEN-1:0]          imm_i;
  logic [`XLEN-1:0]          csr_data_i;
  logic [`CSR_ADDRWIDTH-1:0] csr_addr_i;
  logic [4:0]                csr_uimm_i;
  logic                      csr_uimm_sel_i;
  logic [`REG_ADDRWIDTH-1:0] rd_i;
  logic                      pdt_taken_i;
  logic                      out_valid_o;
  logic [`REG_ADDRWIDTH-1:0] rd_o;
  logic [`XLEN-1:0]          result_o;
  logic                      csr_we_o;
  logic [`CSR_ADDRWIDTH-1:0] csr_addr_o;
  logic [`XLEN-1:0]          csr_wdata_o;
  logic                      branch_valid_o;
  logic                      branch_taken_o;
  logic                      redirect_valid_o;
  logic [`XLEN-1:0]          redirect_pc_o;

  row_t        rows[$];
  int          exp_q[$];       // row index per retire slot, -1 for no pulse
  int          mismatch_cnt = 0;
  int          pulse_cnt = 0;
  int          cycle_cnt = 0;
  int          timeout_cycles = 0;
  logic [31:0] lfsr = 32'ha7335137;

  exu_top dut_i (.*);

  always #20 clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  function automatic logic next_random_bit();
    logic b;
    b = lfsr[0];
    lfsr = (lfsr >> 1) ^ (b ? 32'h80200003 : 32'h0); // x^32+x^22+x^2+x+1
    return b;
  endfunction

  function automatic logic [`XLEN-1:0] random_word();
    logic [`XLEN-1:0] w;
    int               k;
    w = '0;
    for (k = 0; k < `XLEN; k++) w = {w[`XLEN-2:0], next_random_bit()};
    return w;
  endfunction

  // reference ALU, straight from the ISA rules
  function automatic logic [`XLEN-1:0] alu_model(input exu_pkg::alu_op_e op,
                                                 input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
    logic [4:0]         sh;
    logic [2*`XLEN-1:0] ext;
    logic               lt;
    sh  = b[4:0];
    ext = {{`XLEN{a[`XLEN-1]}}, a} >> sh;
    lt  = (a[`XLEN-1] != b[`XLEN-1]) ? a[`XLEN-1] : (a < b); // signed by sign bits
    case (op)
      exu_pkg::ALU_ADD:  return a + b;
      exu_pkg::ALU_SUB:  return a - b;
      exu_pkg::ALU_SLL:  return a << sh;
      exu_pkg::ALU_SLT:  return {{(`XLEN-1){1'b0}}, lt};
      exu_pkg::ALU_SLTU: return {{(`XLEN-1){1'b0}}, a < b};
      exu_pkg::ALU_XOR:  return a ^ b;
      exu_pkg::ALU_SRL:  return a >> sh;
      exu_pkg::ALU_SRA:  return ext[`XLEN-1:0];
      exu_pkg::ALU_OR:   return a | b;
      exu_pkg::ALU_AND:  return a & b;
      default:           return '0;
    endcase
  endfunction

  function automatic row_t blank_row();
    row_t r;
    r     = '0;
    r.vld = 1'b1;
    r.alu = exu_pkg::ALU_ADD;
    return r;
  endfunction

  task automatic add_bubble();
    row_t r;
    r     = blank_row();
    r.vld = 1'b0;
    rows.push_back(r);
  endtask

  // b goes to rs2 or imm, the unused one gets junk
  task automatic add_alu(input exu_pkg::exc_op_e exc, input exu_pkg::alu_op_e op,
                         input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
    row_t r;
    r         = blank_row();
    r.exc     = exc;
    r.alu     = op;
    r.rs1     = a;
    r.rs2     = (exc == exu_pkg::EXC_OPREG) ? b : ~b;
    r.imm     = (exc == exu_pkg::EXC_OPREG) ? ~b : b;
    r.exp_res = alu_model(op, a, b);
    rows.push_back(r);
  endtask

  task automatic add_upper(input exu_pkg::exc_op_e exc, input logic [`XLEN-1:0] pc,
                           input logic [`XLEN-1:0] imm, input logic [`XLEN-1:0] exp_res);
    row_t r;
    r         = blank_row();
    r.exc     = exc;
    r.pc      = pc;
    r.rs1     = 32'hdeadbeef; // must not reach op_a
    r.imm     = imm;
    r.exp_res = exp_res;
    rows.push_back(r);
  endtask

  task automatic add_jump(input exu_pkg::exc_op_e exc, input logic [`XLEN-1:0] pc,
                          input logic [`XLEN-1:0] rs1, input logic [`XLEN-1:0] imm,
                          input logic pdt, input logic [`XLEN-1:0] exp_res,
                          input logic exp_redir, input logic [`XLEN-1:0] exp_rpc);
    row_t r;
    r           = blank_row();
    r.exc       = exc;
    r.pc        = pc;
    r.rs1       = rs1;
    r.imm       = imm;
    r.pdt       = pdt;
    r.exp_res   = exp_res;
    r.exp_taken = 1'b1;
    r.exp_redir = exp_redir;
    r.exp_rpc   = exp_rpc;
    rows.push_back(r);
  endtask

  task automatic add_branch(input exu_pkg::br_op_e br, input logic [`XLEN-1:0] pc,
                            input logic [`XLEN-1:0] rs1, input logic [`XLEN-1:0] rs2,
                            input logic pdt, input logic exp_taken, input logic exp_redir,
                            input logic [`XLEN-1:0] exp_rpc);
    row_t r;
    r           = blank_row();
    r.exc       = exu_pkg::EXC_BRANCH;
    r.br        = br;
    r.pc        = pc;
    r.rs1       = rs1;
    r.rs2       = rs2;
    r.imm       = 32'h40;
    r.pdt       = pdt;
    r.exp_taken = exp_taken;
    r.exp_redir = exp_redir;
    r.exp_rpc   = exp_rpc;
    rows.push_back(r);
  endtask

  task automatic add_csr(input exu_pkg::csr_op_e op, input logic usel,
                         input logic [`XLEN-1:0] rs1, input logic [4:0] uimm,
                         input logic [`XLEN-1:0] old, input logic [`XLEN-1:0] exp_wdata);
    row_t r;
    r           = blank_row();
    r.exc       = exu_pkg::EXC_CSR;
    r.csr       = op;
    r.usel      = usel;
    r.rs1       = rs1;
    r.uimm      = uimm;
    r.csr_data  = old;
    r.exp_res   = old; // rd gets the old csr value
    r.exp_wdata = exp_wdata;
    rows.push_back(r);
  endtask

  task automatic build_table();
    int k;
    add_bubble();
    add_bubble();
    for (k = 0; k < 10; k++) add_alu(exu_pkg::EXC_OPREG, exu_pkg::alu_op_e'(k[3:0]),
                                     random_word(), random_word());
    for (k = 0; k < 10; k++) add_alu(exu_pkg::EXC_OPIMM, exu_pkg::alu_op_e'(k[3:0]),
                                     random_word(), random_word());
    add_alu(exu_pkg::EXC_OPREG, exu_pkg::ALU_SLT, 32'hfffffff0, 32'h10);
    add_alu(exu_pkg::EXC_OPREG, exu_pkg::ALU_SLTU, 32'hfffffff0, 32'h10);
    add_alu(exu_pkg::EXC_OPIMM, exu_pkg::ALU_SRA, 32'h80000000, 32'h4);
    add_upper(exu_pkg::EXC_LUI, 32'h200, 32'h12345abc, 32'h12345000);
    add_upper(exu_pkg::EXC_AUIPC, 32'h200, 32'h00001fff, 32'h00001200);
    add_bubble();
    // jumps, each mispredict followed by a row that must vanish
    add_jump(exu_pkg::EXC_JAL, 32'h300, 32'h0, 32'h80, 1'b1, 32'h304, 1'b0, 32'h380);
    add_jump(exu_pkg::EXC_JAL, 32'h310, 32'h0, 32'h20, 1'b0, 32'h314, 1'b1, 32'h330);
    add_alu(exu_pkg::EXC_OPREG, exu_pkg::ALU_ADD, 32'h1, 32'h2);
    add_jump(exu_pkg::EXC_JALR, 32'h400, 32'h1001, 32'h10, 1'b0, 32'h404, 1'b1, 32'h1010);
    add_alu(exu_pkg::EXC_OPREG, exu_pkg::ALU_ADD, 32'h1, 32'h2);
    add_jump(exu_pkg::EXC_JALR, 32'h410, 32'h2000, 32'h7, 1'b1, 32'h414, 1'b0, 32'h2006);
    add_branch(exu_pkg::BR_BEQ, 32'h600, 32'h5, 32'h5, 1'b1, 1'b1, 1'b0, 32'h640);
    add_branch(exu_pkg::BR_BEQ, 32'h610, 32'h5, 32'h6, 1'b1, 1'b0, 1'b1, 32'h614);
    add_alu(exu_pkg::EXC_OPREG, exu_pkg::ALU_ADD, 32'h1, 32'h2);
    add_branch(exu_pkg::BR_BNE, 32'h620, 32'h5, 32'h6, 1'b0, 1'b1, 1'b1, 32'h660);
    add_alu(exu_pkg::EXC_OPREG, exu_pkg::ALU_ADD, 32'h1, 32'h2);
    add_branch(exu_pkg::BR_BNE, 32'h630, 32'h7, 32'h7, 1'b0, 1'b0, 1'b0, 32'h670);
    add_branch(exu_pkg::BR_BLT, 32'h640, 32'hfffffffe, 32'h1, 1'b1, 1'b1, 1'b0, 32'h680);
    add_branch(exu_pkg::BR_BLT, 32'h650, 32'h1, 32'hfffffffe, 1'b0, 1'b0, 1'b0, 32'h690);
    add_branch(exu_pkg::BR_BGE, 32'h660, 32'h1, 32'hfffffffe, 1'b0, 1'b1, 1'b1, 32'h6a0);
    add_alu(exu_pkg::EXC_OPREG, exu_pkg::ALU_ADD, 32'h1, 32'h2);
    add_branch(exu_pkg::BR_BGE, 32'h670, 32'hfffffffe, 32'h1, 1'b1, 1'b0, 1'b1, 32'h674);
    add_alu(exu_pkg::EXC_OPREG, exu_pkg::ALU_ADD, 32'h1, 32'h2);
    add_branch(exu_pkg::BR_BLTU, 32'h680, 32'h1, 32'hfffffffe, 1'b1, 1'b1, 1'b0, 32'h6c0);
    add_branch(exu_pkg::BR_BLTU, 32'h690, 32'hfffffffe, 32'h1, 1'b1, 1'b0, 1'b1, 32'h694);
    add_alu(exu_pkg::EXC_OPREG, exu_pkg::ALU_ADD, 32'h1, 32'h2);
    add_branch(exu_pkg::BR_BGEU, 32'h6a0, 32'hfffffffe, 32'h1, 1'b0, 1'b1, 1'b1, 32'h6e0);
    add_alu(exu_pkg::EXC_OPREG, exu_pkg::ALU_ADD, 32'h1, 32'h2);
    add_branch(exu_pkg::BR_BGEU, 32'h6b0, 32'h3, 32'h3, 1'b1, 1'b1, 1'b0, 32'h6f0);
    add_csr(exu_pkg::CSR_RW, 1'b0, 32'h1234, 5'h0, 32'hffff0000, 32'h00001234);
    add_csr(exu_pkg::CSR_RS, 1'b0, 32'h0f0f, 5'h0, 32'hf0000000, 32'hf0000f0f);
    add_csr(exu_pkg::CSR_RC, 1'b0, 32'h00ff, 5'h0, 32'h123456ff, 32'h12345600);
    add_csr(exu_pkg::CSR_RW, 1'b1, 32'haaaa, 5'h1f, 32'h5555, 32'h0000001f);
    add_csr(exu_pkg::CSR_RS, 1'b1, 32'haaaa, 5'h03, 32'h0100, 32'h00000103);
    add_csr(exu_pkg::CSR_RC, 1'b1, 32'haaaa, 5'h11, 32'h00ff, 32'h000000ee);
    add_csr(exu_pkg::CSR_NONE, 1'b0, 32'h1, 5'h0, 32'h77, 32'h77); // read only, no write
  endtask

  task automatic check_result(input string sig, input int row,
                              input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] want);
    if (got !== want) begin
      mismatch_cnt++;
      $display("Mismatch %s got %h exp %h (row %0d)", sig, got, want, row);
    end
  endtask

  task automatic check_flag(input string sig, input int row, input logic got, input logic want);
    if (got !== want) begin
      mismatch_cnt++;
      $display("Mismatch %s got %h exp %h (row %0d)", sig, got, want, row);
    end
  endtask

  task automatic check_branch(input int row, input exu_pkg::br_op_e op,
                              input logic got, input logic want);
    if (got !== want) begin
      mismatch_cnt++;
      $display("Mismatch branch_taken_o got %h exp %h (row %0d, %s)", got, want, row,
               op.name());
    end
  endtask

  task automatic check_csr(input int row, input exu_pkg::csr_op_e op,
                           input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] want);
    if (got !== want) begin
      mismatch_cnt++;
      $display("Mismatch csr_wdata_o got %h exp %h (row %0d, %s)", got, want, row, op.name());
    end
  endtask

  task automatic check_outputs();
    int   idx;
    row_t r;
    logic is_flow;
    logic is_wr;
    idx = exp_q.pop_front();
    if (idx < 0) begin
      if (out_valid_o !== 1'b0) begin
        pulse_cnt++;
        $display("unexpected out_valid_o pulse at cycle %0d", cycle_cnt);
      end
      check_flag("csr_we_o", idx, csr_we_o, 1'b0);
      check_flag("branch_valid_o", idx, branch_valid_o, 1'b0);
      check_flag("redirect_valid_o", idx, redirect_valid_o, 1'b0);
    end else begin
      r       = rows[idx];
      is_flow = r.exc inside {exu_pkg::EXC_BRANCH, exu_pkg::EXC_JAL, exu_pkg::EXC_JALR};
      is_wr   = (r.exc == exu_pkg::EXC_CSR) && (r.csr != exu_pkg::CSR_NONE);
      if (out_valid_o !== 1'b1) begin
        pulse_cnt++;
        $display("missing out_valid_o pulse for row %0d", idx);
      end
      check_result("rd_o", idx, `XLEN'(rd_o), `XLEN'(idx[`REG_ADDRWIDTH-1:0]));
      if (r.exc != exu_pkg::EXC_BRANCH) check_result("result_o", idx, result_o, r.exp_res);
      check_flag("branch_valid_o", idx, branch_valid_o, is_flow);
      check_flag("redirect_valid_o", idx, redirect_valid_o, r.exp_redir);
      if (is_flow) begin
        check_branch(idx, r.br, branch_taken_o, r.exp_taken);
        check_result("redirect_pc_o", idx, redirect_pc_o, r.exp_rpc);
      end
      check_flag("csr_we_o", idx, csr_we_o, is_wr);
      if (is_wr) begin
        check_csr(idx, r.csr, csr_wdata_o, r.exp_wdata);
        check_result("csr_addr_o", idx, `XLEN'(csr_addr_o), `XLEN'(12'h300 + idx));
      end
    end
  endtask

  task automatic drive_row(input int idx);
    row_t r;
    r              = rows[idx];
    in_valid_i     = r.vld;
    exc_op_i       = r.exc;
    alu_op_i       = r.alu;
    br_op_i        = r.br;
    csr_op_i       = r.csr;
    pc_i           = r.pc;
    rs1_data_i     = r.rs1;
    rs2_data_i     = r.rs2;
    imm_i          = r.imm;
    csr_data_i     = r.csr_data;
    csr_addr_i     = `CSR_ADDRWIDTH'(12'h300 + idx);
    csr_uimm_i     = r.uimm;
    csr_uimm_sel_i = r.usel;
    rd_i           = idx[`REG_ADDRWIDTH-1:0];
    pdt_taken_i    = r.pdt;
  endtask

  // watchdog
  initial begin
    @(posedge clk);
    while (cycle_cnt < timeout_cycles) @(posedge clk);
    $display("timeout, run still busy after %0d cycles", cycle_cnt);
    $display("Test failed");
    $finish;
  end

  initial begin
    int   i;
    logic live;
    logic squash_next;
    clk            = 1'b0;
    rst_n_i        = 1'b0;
    in_valid_i     = 1'b0;
    exc_op_i       = exu_pkg::EXC_NONE;
    alu_op_i       = exu_pkg::ALU_ADD;
    br_op_i        = exu_pkg::BR_BEQ;
    csr_op_i       = exu_pkg::CSR_NONE;
    pc_i           = '0;
    rs1_data_i     = '0;
    rs2_data_i     = '0;
    imm_i          = '0;
    csr_data_i     = '0;
    csr_addr_i     = '0;
    csr_uimm_i     = '0;
    csr_uimm_sel_i = 1'b0;
    rd_i           = '0;
    pdt_taken_i    = 1'b0;
    squash_next    = 1'b0;
    build_table();
    timeout_cycles = rows.size() + 4 + 10;
    repeat (4) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    exp_q.push_back(-1); // pipe still empty for two slots
    exp_q.push_back(-1);
    for (i = 0; i < rows.size() + 2; i++) begin
      check_outputs();
      if (i < rows.size()) begin
        drive_row(i);
        live        = rows[i].vld && !squash_next;
        exp_q.push_back(live ? i : -1);
        squash_next = live && rows[i].exp_redir;
      end else begin
        in_valid_i  = 1'b0;
        exp_q.push_back(-1);
        squash_next = 1'b0;
      end
      @(posedge clk);
      #1;
    end
    $display("errors: %0d mismatches, %0d out_valid_o pulse errors", mismatch_cnt, pulse_cnt);
    if (mismatch_cnt == 0 && pulse_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* exu.f */
+incdir+.
exu_pkg.sv
ex_issue_if.sv
ex_result_if.sv
ex_issue.sv
ex_alu.sv
ex_branch.sv
ex_csr.sv
ex_retire.sv
exu_top.sv
tb_exu.sv

/* Makefile */
SRCS := $(wildcard *.sv *.svh)

.PHONY: run clean

run: obj_dir/Vtb_exu
	./obj_dir/Vtb_exu > sim.log 2>&1; cat sim.log
	grep -qx "Test passed" sim.log

obj_dir/Vtb_exu: exu.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_exu -f exu.f -o Vtb_exu

clean:
	rm -rf obj_dir sim.log
